// ==== testbench/exCore_trace.txt ====
# cmd ixt rs rt rn imm flush memDelay memData expWbValue expSr test
# all columns hex except test, expWbValue is ignored when no writeback is expected
01 10 0 0 1 000000005 0 0 0 0000000000000005 00 1
01 10 0 0 2 000000003 0 0 0 0000000000000003 00 1
02 00 1 2 3 000000000 0 0 0 0000000000000008 00 1
02 01 3 2 4 000000000 0 0 0 0000000000000005 20 1
02 02 4 3 5 000000000 0 0 0 0000000000000000 20 1
02 03 4 3 6 000000000 0 0 0 000000000000000d 20 1
02 00 6 4 7 000000000 0 0 0 0000000000000012 00 1
01 10 0 0 8 1ffffffff 0 0 0 ffffffffffffffff 00 2
02 00 8 8 9 000000000 0 0 0 fffffffffffffffe a2 2
02 01 1 1 a 000000000 0 0 0 0000000000000000 31 2
03 08 1 4 0 000000000 0 0 0 0000000000000000 31 2
03 09 3 1 0 000000000 0 0 0 0000000000000000 21 2
03 09 1 3 0 000000000 0 0 0 0000000000000000 82 2
02 02 1 2 b 000000000 0 0 0 0000000000000001 82 2
05 11 0 0 0 000000000 0 0 0 0000000000000000 82 3
01 10 0 0 c 000000040 0 0 0 0000000000000040 82 3
04 10 c 0 d 000000008 0 0 1111 0000000000001111 82 4
04 10 c 0 d 000000010 0 1 2222 0000000000002222 82 4
04 10 c 0 d 000000018 0 2 3333 0000000000003333 82 4
04 10 c 0 d 000000020 0 3 4444 0000000000004444 82 4
04 10 c 0 d 000000028 0 4 5555 0000000000005555 82 4
04 10 c 0 d 1fffffff8 0 5 6666 0000000000006666 82 4
02 00 d c e 000000000 0 0 0 00000000000066a6 00 4
01 10 0 0 5 000000077 1 0 0 0000000000000000 00 5
02 00 5 0 f 000000000 0 0 0 0000000000000000 11 5
02 01 1 2 7 000000000 1 0 0 0000000000000000 11 5
02 03 7 0 9 000000000 0 0 0 0000000000000012 11 5
01 10 0 0 0 000000099 0 0 0 0000000000000099 11 6
02 03 0 0 a 000000000 0 0 0 0000000000000000 11 6

// ==== src.f ====
+incdir+hdl
hdl/exOpPkg.sv
hdl/exRegPkg.sv
hdl/exPipeLatch.sv
hdl/exRegFile.sv
hdl/exStage1.sv
hdl/exStage2.sv
hdl/exCore.sv
testbench/exCore_chk.sv
testbench/exCoreTb.sv

// ==== testbench/exCoreTb.sv ====
`timescale 1ns/1ns
`include "exCore_macros.svh"

module exCoreTb;

	typedef struct packed {
		logic [5:0]  cmd;
		logic [5:0]  ixt;
		logic [3:0]  rs;
		logic [3:0]  rt;
		logic [3:0]  rn;
		logic [32:0] imm;
		logic        flush;
		logic [3:0]  delay;		// Cycles before memDataOk
		logic [63:0] memData;
		logic [63:0] expWb;
		logic [7:0]  expSr;		// SR after this op
		logic [7:0]  test;
		logic        gap;		// Inserted NOP, not from trace
	} slotT;

	logic                  clock;
	logic                  arstN;
	exOpPkg::uCmd          opUCmd;
	exOpPkg::uIxt          opUIxt;
	exRegPkg::regId        regIdRs;
	exRegPkg::regId        regIdRt;
	exRegPkg::regId        regIdRn;
	logic [`EX_IMM_W-1:0]  regValImm;
	logic                  opBraFlush;
	logic [`EX_DATA_W-1:0] memDataIn;
	logic                  memDataOk;
	logic                  exHold;
	logic [`EX_ADDR_W-1:0] memAddr;
	logic                  memReq;
	exRegPkg::regId        wbId;
	logic [`EX_DATA_W-1:0] wbValue;
	logic                  wbValid;
	exRegPkg::srVal        srOut;

	slotT        slots[$];		// Trace ops plus NOP gaps
	logic [63:0] regModel [0:15];	// Expected GPR contents
	int          errCount [0:255];	// Per test
	int          errors = 0;
	int          checks = 0;
	int          traceLen = 0;
	int          cycleLimit = 0;
	int          cycleCnt = 0;
	int          testsPassed = 0;
	int          testsFailed = 0;
	logic [31:0] lfsr;

	exCore exCore_inst (
		.clock(clock), .arstN(arstN),
		.opUCmd(opUCmd), .opUIxt(opUIxt),
		.regIdRs(regIdRs), .regIdRt(regIdRt), .regIdRn(regIdRn), .regValImm(regValImm),
		.opBraFlush(opBraFlush), .memDataIn(memDataIn), .memDataOk(memDataOk),
		.exHold(exHold), .memAddr(memAddr), .memReq(memReq),
		.wbId(wbId), .wbValue(wbValue), .wbValid(wbValid), .srOut(srOut)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;		// 40 ns period
	end

	// Taps 32,22,2,1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic slotT gapSlot(input logic [7:0] test, input logic [7:0] sr);
		slotT g;
		g = '0;
		g.cmd   = exOpPkg::UCMD_NOP;
		g.ixt   = exOpPkg::UIXT_NOP;
		g.expSr = sr;					// SR carries over a bubble
		g.test  = test;
		g.gap   = 1'b1;
		return g;
	endfunction

	task automatic checkValue(input string name, input logic [63:0] got,
		input logic [63:0] exp, input int test);
		checks++;
		if (got !== exp) begin
			$display("ERROR test %0d %s got %h expected %h", test, name, got, exp);
			errCount[test]++;
			errors++;
		end
	endtask

	task automatic reportTest(input int test);
		if (errCount[test] == 0) begin
			$display("Test %0d passed", test);
			testsPassed++;
		end else begin
			$display("Test %0d failed with %0d errors", test, errCount[test]);
			testsFailed++;
		end
	endtask

	task automatic loadTrace();
		int          fd;
		int          n;
		int          gaps;
		int          fTest;
		string       line;
		slotT        s;
		logic [7:0]  lastTest;
		logic [7:0]  lastSr;
		logic [5:0]  fCmd;
		logic [5:0]  fIxt;
		logic [3:0]  fRs;
		logic [3:0]  fRt;
		logic [3:0]  fRn;
		logic [32:0] fImm;
		logic        fFlush;
		logic [3:0]  fDelay;
		logic [63:0] fMem;
		logic [63:0] fWb;
		logic [7:0]  fSr;
		lastTest = 0;
		lastSr   = 0;
		fd = $fopen("testbench/exCore_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;				// Blank or column legend
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %d", fCmd, fIxt, fRs, fRt,
				fRn, fImm, fFlush, fDelay, fMem, fWb, fSr, fTest);
			if (n != 12) begin
				$display("Malformed trace line: %s", line);
				errors++;
				continue;
			end
			traceLen++;
			if (lastTest != 0 && fTest != lastTest) begin
				lfsr = lfsrNext(lfsr);
				gaps = lfsr[0];
				lfsr = lfsrNext(lfsr);
				gaps = gaps * 2 + lfsr[0];	// 0 to 3 bubbles between groups
				repeat (gaps) slots.push_back(gapSlot(lastTest, lastSr));
			end
			s = '0;
			s.cmd     = fCmd;
			s.ixt     = fIxt;
			s.rs      = fRs;
			s.rt      = fRt;
			s.rn      = fRn;
			s.imm     = fImm;
			s.flush   = fFlush;
			s.delay   = fDelay;
			s.memData = fMem;
			s.expWb   = fWb;
			s.expSr   = fSr;
			s.test    = fTest[7:0];
			slots.push_back(s);
			lastTest = fTest[7:0];
			lastSr   = fSr;
		end
		$fclose(fd);
		repeat (3) slots.push_back(gapSlot(lastTest, lastSr));	// Drain EX2 and SR
	endtask

	initial begin
		@(posedge clock);
		forever begin
			@(posedge clock);
			cycleCnt++;
			if (cycleLimit > 0 && cycleCnt > cycleLimit) begin
				$display("Timeout after %0d cycles, the trace did not complete", cycleCnt);
				$display("SIMULATION FAILED");
				$finish;
			end
		end
	end

	initial begin
		slotT        cur;
		slotT        prv;			// Op in EX2
		slotT        old;			// Op whose SR write just landed
		int          holdCnt;
		int          expHold;
		int          activeTest;
		logic        loadOp;
		logic        wbExp;
		logic [63:0] immExt;
		logic [47:0] addrExp;
		arstN      = 1'b0;
		opUCmd     = exOpPkg::UCMD_NOP;
		opUIxt     = exOpPkg::UIXT_NOP;
		regIdRs    = '0;
		regIdRt    = '0;
		regIdRn    = '0;
		regValImm  = '0;
		opBraFlush = 1'b0;
		memDataIn  = '0;
		memDataOk  = 1'b0;
		lfsr       = 32'hc013;
		for (int i = 0; i < 256; i++)
			errCount[i] = 0;
		for (int i = 0; i < 16; i++)
			regModel[i] = '0;
		loadTrace();
		cycleLimit = (traceLen + 2) * 20;
		repeat (10) @(posedge clock);
		#5 arstN = 1'b1;
		prv = gapSlot(0, 0);
		old = prv;
		activeTest = 0;
		foreach (slots[k]) begin
			cur = slots[k];
			@(posedge clock);
			#5;
			checkValue("srOut", srOut, old.expSr, old.test);
			if (!old.gap && old.test != activeTest) begin
				if (activeTest != 0)
					reportTest(activeTest);	// Last SR check of that test done
				activeTest = old.test;
			end
			opUCmd     = exOpPkg::uCmd'(cur.cmd);
			opUIxt     = exOpPkg::uIxt'(cur.ixt);
			regIdRs    = cur.rs;
			regIdRt    = cur.rt;
			regIdRn    = cur.rn;
			regValImm  = cur.imm;
			opBraFlush = prv.flush;		// Flush targets the op now in EX2
			loadOp  = (prv.cmd == exOpPkg::UCMD_MOV_MR) && !prv.flush;
			immExt  = {{31{prv.imm[32]}}, prv.imm};
			addrExp = regModel[prv.rs][47:0] + immExt[47:0];
			holdCnt = 0;
			while (1) begin
				memDataOk = loadOp && (holdCnt == prv.delay);	// Memory answers after delay
				memDataIn = prv.memData;
				@(negedge clock);
				checkValue("memReq", memReq, loadOp, prv.test);
				if (loadOp)
					checkValue("memAddr", memAddr, addrExp, prv.test);
				if (!exHold)
					break;
				holdCnt++;
				@(posedge clock);
				#5;
			end
			if (prv.cmd == exOpPkg::UCMD_IXT && prv.ixt == exOpPkg::UIXT_SLEEP && !prv.flush)
				expHold = `EX_SLEEP_CYC;
			else if (loadOp)
				expHold = prv.delay;
			else
				expHold = 0;
			checks++;
			if (holdCnt != expHold) begin
				$display("Test %0d: exHold lasted %0d cycles instead of %0d",
					prv.test, holdCnt, expHold);
				errCount[prv.test]++;
				errors++;
			end
			wbExp = !prv.flush && (prv.cmd == exOpPkg::UCMD_MOV_IR ||
				prv.cmd == exOpPkg::UCMD_ALU3 || prv.cmd == exOpPkg::UCMD_MOV_MR);
			checkValue("wbValid", wbValid, wbExp, prv.test);
			if (wbExp) begin
				checkValue("wbId", wbId, prv.rn, prv.test);
				checkValue("wbValue", wbValue, prv.expWb, prv.test);
				if (prv.rn != 0)
					regModel[prv.rn] = prv.expWb;	// ZZR keeps zero
			end
			old = prv;
			prv = cur;
		end
		if (activeTest != 0)
			reportTest(activeTest);
		if (exCore_inst.chk_inst.assertFails != 0)
			$display("Bound assertions failed %0d times", exCore_inst.chk_inst.assertFails);
		errors += exCore_inst.chk_inst.assertFails;
		$display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
			testsPassed, testsFailed, checks, errors);
		if (errors == 0 && testsFailed == 0 && traceLen > 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== testbench/exCore_chk.sv ====
`timescale 1ns/1ns

module exCoreChk (
	input logic         clock,
	input logic         arstN,
	input logic         exHold,
	input logic         memReq,
	input logic         memDataOk,
	input logic         wbValid,
	input logic         srWrEn,
	input logic         opBraFlush,
	input exOpPkg::uCmd opCmd,		// Op sitting in EX2
	input exOpPkg::uIxt opIxt
);

	logic sleepOp;		// Live SLEEP in EX2
	int   assertFails = 0;	// Failures so far

	assign sleepOp = (opCmd == exOpPkg::UCMD_IXT) && (opIxt == exOpPkg::UIXT_SLEEP) &&
		!opBraFlush;

	// Pipe is quiet while reset is held
	resetQuiet: assert property (@(posedge clock) !arstN |-> !exHold && !memReq && !wbValid)
		else begin
			$error("exHold, memReq or wbValid high during reset");
			assertFails++;
		end

	// SLEEP stall is exactly 15 cycles
	sleepLen: assert property (@(posedge clock) disable iff (!arstN)
		$rose(exHold) && sleepOp |-> exHold[*15] ##1 !exHold)
		else begin
			$error("SLEEP hold length is not 15 cycles");
			assertFails++;
		end

	sleepNoWb: assert property (@(posedge clock) disable iff (!arstN) sleepOp |-> !wbValid)
		else begin
			$error("Writeback during SLEEP");
			assertFails++;
		end

	// Squashed op touches neither GPR nor SR
	flushQuiet: assert property (@(posedge clock) disable iff (!arstN)
		opBraFlush |-> !wbValid && !srWrEn)
		else begin
			$error("Flushed op wrote back");
			assertFails++;
		end

	// Load stays in EX2 until its data is back
	loadHold: assert property (@(posedge clock) disable iff (!arstN)
		memReq && !memDataOk |=> memReq)
		else begin
			$error("Load left EX2 before memDataOk");
			assertFails++;
		end

endmodule

bind exCore exCoreChk chk_inst (
	.clock(clock),
	.arstN(arstN),
	.exHold(exHold),
	.memReq(memReq),
	.memDataOk(memDataOk),
	.wbValid(wbValid),
	.srWrEn(srWrEn),
	.opBraFlush(opBraFlush),
	.opCmd(opE2.cmd),
	.opIxt(opE2.ixt)
);

// ==== hdl/exCore.sv ====
`timescale 1ns/1ns
`include "exCore_macros.svh"

module exCore (
	input  logic                  clock,
	input  logic                  arstN,
	input  exOpPkg::uCmd          opUCmd,
	input  exOpPkg::uIxt          opUIxt,
	input  exRegPkg::regId        regIdRs,
	input  exRegPkg::regId        regIdRt,
	input  exRegPkg::regId        regIdRn,
	input  logic [`EX_IMM_W-1:0]  regValImm,
	input  logic                  opBraFlush,
	input  logic [`EX_DATA_W-1:0] memDataIn,
	input  logic                  memDataOk,
	output logic                  exHold,
	output logic [`EX_ADDR_W-1:0] memAddr,
	output logic                  memReq,
	output exRegPkg::regId        wbId,
	output logic [`EX_DATA_W-1:0] wbValue,
	output logic                  wbValid,
	output exRegPkg::srVal        srOut
);

	exRegPkg::regId        rdIdA;		// EX1 source IDs
	exRegPkg::regId        rdIdB;
	logic [`EX_DATA_W-1:0] rdValA;		// Forwarded source values
	logic [`EX_DATA_W-1:0] rdValB;
	logic [`EX_DATA_W-1:0] aluResE1;
	exRegPkg::aluFlag      aluFlagsE1;
	logic [`EX_ADDR_W-1:0] memAddrE1;
	exRegPkg::regId        regIdRnE2;	// EX2 side of the latches
	logic [`EX_DATA_W-1:0] aluResE2;
	exRegPkg::aluFlag      aluFlagsE2;
	logic [`EX_ADDR_W-1:0] memAddrE2;
	exOpPkg::uOp           opE2;
	logic                  srWrEn;
	exRegPkg::srVal        srNext;

	exRegFile regFile_inst (
		.clock(clock), .arstN(arstN),
		.rdIdA(rdIdA), .rdIdB(rdIdB), .rdValA(rdValA), .rdValB(rdValB),
		.wrEn(wbValid), .wrId(wbId), .wrVal(wbValue),
		.srWrEn(srWrEn), .srIn(srNext), .srOut(srOut)
	);

	exStage1 stage1_inst (
		.opUCmd(opUCmd), .opUIxt(opUIxt),
		.regIdRs(regIdRs), .regIdRt(regIdRt), .regValImm(regValImm),
		.regValRs(rdValA), .regValRt(rdValB),
		.aluRes(aluResE1), .aluFlags(aluFlagsE1), .memAddrNext(memAddrE1),
		.rdIdA(rdIdA), .rdIdB(rdIdB)
	);

	// EX1/EX2 boundary, younger-op squash is left to the decoder
	exPipeLatch #(.payloadT(exRegPkg::regId), .resetVal(exRegPkg::REG_ZZR)) dstLatch_inst (
		.clock(clock), .arstN(arstN), .hold(exHold), .flush(1'b0),
		.d(regIdRn), .q(regIdRnE2)
	);

	exPipeLatch #(.payloadT(logic [`EX_DATA_W-1:0])) resLatch_inst (
		.clock(clock), .arstN(arstN), .hold(exHold), .flush(1'b0),
		.d(aluResE1), .q(aluResE2)
	);

	exPipeLatch #(.payloadT(exRegPkg::aluFlag)) flagLatch_inst (
		.clock(clock), .arstN(arstN), .hold(exHold), .flush(1'b0),
		.d(aluFlagsE1), .q(aluFlagsE2)
	);

	exPipeLatch #(.payloadT(logic [`EX_ADDR_W-1:0])) addrLatch_inst (
		.clock(clock), .arstN(arstN), .hold(exHold), .flush(1'b0),
		.d(memAddrE1), .q(memAddrE2)
	);

	exPipeLatch #(.payloadT(exOpPkg::uOp), .resetVal(exOpPkg::UOP_NOP)) opLatch_inst (
		.clock(clock), .arstN(arstN), .hold(exHold), .flush(1'b0),
		.d('{cmd: opUCmd, ixt: opUIxt}), .q(opE2)
	);

	exStage2 stage2_inst (
		.clock(clock), .arstN(arstN),
		.opUCmd(opE2.cmd), .opUIxt(opE2.ixt), .regIdRn(regIdRnE2),
		.aluRes(aluResE2), .aluFlags(aluFlagsE2), .memAddrIn(memAddrE2),
		.opBraFlush(opBraFlush), .memDataIn(memDataIn), .memDataOk(memDataOk),
		.srIn(srOut), .exHold(exHold), .memReq(memReq), .memAddr(memAddr),
		.wbValid(wbValid), .wbId(wbId), .wbValue(wbValue),
		.srWrEn(srWrEn), .srNext(srNext)
	);

endmodule

// ==== hdl/exStage2.sv ====
`timescale 1ns/1ns
`include "exCore_macros.svh"

module exStage2 (
	input  logic                  clock,
	input  logic                  arstN,
	input  exOpPkg::uCmd          opUCmd,
	input  exOpPkg::uIxt          opUIxt,
	input  exRegPkg::regId        regIdRn,		// Destination from EX1 latch
	input  logic [`EX_DATA_W-1:0] aluRes,		// Latched ALU result
	input  exRegPkg::aluFlag      aluFlags,		// Latched flags
	input  logic [`EX_ADDR_W-1:0] memAddrIn,	// Latched load address
	input  logic                  opBraFlush,	// Squash the op in EX2
	input  logic [`EX_DATA_W-1:0] memDataIn,
	input  logic                  memDataOk,	// One-cycle data ready
	input  exRegPkg::srVal        srIn,			// Current SR
	output logic                  exHold,
	output logic                  memReq,
	output logic [`EX_ADDR_W-1:0] memAddr,
	output logic                  wbValid,
	output exRegPkg::regId        wbId,
	output logic [`EX_DATA_W-1:0] wbValue,
	output logic                  srWrEn,
	output exRegPkg::srVal        srNext
);

	exOpPkg::uCmd cmdLive;		// NOP when flushed
	logic         opLive;
	logic         doOut;		// GPR write this cycle
	logic         doSr;			// SR write this cycle
	logic         isLoad;
	logic [3:0]   holdTarget;	// Cycles to hold for this op
	logic [3:0]   holdCyc;		// Cycles held so far

	always_comb begin
		opLive     = !opBraFlush;
		cmdLive    = opLive ? opUCmd : exOpPkg::UCMD_NOP;
		doOut      = 1'b0;
		doSr       = 1'b0;
		isLoad     = 1'b0;
		holdTarget = 4'd0;
		wbValue    = aluRes;			// Forward by default

		case (cmdLive)
			exOpPkg::UCMD_MOV_IR: begin
				doOut = 1'b1;
			end
			exOpPkg::UCMD_ALU3: begin
				doOut = 1'b1;
				// Logic ops leave SR alone
				doSr  = (opUIxt == exOpPkg::UIXT_ADD) || (opUIxt == exOpPkg::UIXT_SUB);
			end
			exOpPkg::UCMD_ALUCMP: begin
				doSr = 1'b1;			// Flags only, no GPR
			end
			exOpPkg::UCMD_MOV_MR: begin
				isLoad  = 1'b1;
				wbValue = memDataIn;
				doOut   = memDataOk;	// Write once data is back
			end
			exOpPkg::UCMD_IXT: begin
				if (opUIxt == exOpPkg::UIXT_SLEEP)
					holdTarget = 4'(`EX_SLEEP_CYC);
			end
			default: begin
			end
		endcase
	end

	// Stall until the countdown ends or load data arrives
	assign exHold = (holdCyc < holdTarget) || (isLoad && !memDataOk);

	assign memReq  = isLoad;
	assign memAddr = memAddrIn;

	assign wbValid = doOut;
	assign wbId    = opLive ? regIdRn : exRegPkg::REG_ZZR;	// Flush goes to ZZR

	always_comb begin
		srNext = srIn;					// Keep untouched fields
		srNext[exRegPkg::SR_T] = aluFlags[0];
		srNext[exRegPkg::SR_S] = aluFlags[1];
		srNext[exRegPkg::SR_CV_HI:exRegPkg::SR_CV_LO] = aluFlags[5:2];
	end

	assign srWrEn = doSr;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			holdCyc <= 4'd0;
		else if (exHold)
			holdCyc <= holdCyc + {3'd0, (holdCyc != 4'hF)};	// Saturate at 15
		else
			holdCyc <= 4'd0;			// Rearm for next op
	end

endmodule

// ==== hdl/exStage1.sv ====
`timescale 1ns/1ns
`include "exCore_macros.svh"

module exStage1 (
	input  exOpPkg::uCmd          opUCmd,
	input  exOpPkg::uIxt          opUIxt,
	input  exRegPkg::regId        regIdRs,		// Source A, ALU / base
	input  exRegPkg::regId        regIdRt,		// Source B, ALU
	input  logic [`EX_IMM_W-1:0]  regValImm,	// Immediate from decode
	input  logic [`EX_DATA_W-1:0] regValRs,		// Rs value, already forwarded
	input  logic [`EX_DATA_W-1:0] regValRt,		// Rt value, already forwarded
	output logic [`EX_DATA_W-1:0] aluRes,
	output exRegPkg::aluFlag      aluFlags,
	output logic [`EX_ADDR_W-1:0] memAddrNext,	// Load address for EX2
	output exRegPkg::regId        rdIdA,
	output exRegPkg::regId        rdIdB
);

	logic [`EX_DATA_W-1:0] immExt;		// Sign extended immediate
	logic [`EX_DATA_W-1:0] opB;			// Rt, inverted for subtract
	logic [`EX_DATA_W-1:0] sum;
	logic                  isSub;
	logic                  carryOut;
	logic                  ovf;
	logic                  zero;
	logic                  sign;
	logic                  lessS;		// Signed Rs < Rt after subtract
	logic                  tBit;

	assign rdIdA = regIdRs;				// Register file read ports
	assign rdIdB = regIdRt;

	assign immExt = {{(`EX_DATA_W - `EX_IMM_W){regValImm[`EX_IMM_W-1]}}, regValImm};

	// Compares always subtract
	assign isSub = (opUCmd == exOpPkg::UCMD_ALUCMP) ||
		((opUCmd == exOpPkg::UCMD_ALU3) && (opUIxt == exOpPkg::UIXT_SUB));

	assign opB = isSub ? ~regValRt : regValRt;

	// Shared adder, +1 completes two's complement
	assign {carryOut, sum} = {1'b0, regValRs} + {1'b0, opB} + {{`EX_DATA_W{1'b0}}, isSub};

	assign ovf   = (regValRs[`EX_DATA_W-1] == opB[`EX_DATA_W-1]) &&
		(sum[`EX_DATA_W-1] != regValRs[`EX_DATA_W-1]);
	assign zero  = (sum == '0);
	assign sign  = sum[`EX_DATA_W-1];
	assign lessS = sign ^ ovf;

	always_comb begin
		aluRes = sum;					// Adder by default
		case (opUCmd)
			exOpPkg::UCMD_MOV_IR: aluRes = immExt;
			exOpPkg::UCMD_ALU3: begin
				case (opUIxt)
					exOpPkg::UIXT_AND: aluRes = regValRs & regValRt;
					exOpPkg::UIXT_OR:  aluRes = regValRs | regValRt;
					default:           aluRes = sum;	// ADD, SUB
				endcase
			end
			default: aluRes = sum;
		endcase
	end

	always_comb begin
		tBit = zero;					// ADD/SUB: T marks zero result
		if (opUCmd == exOpPkg::UCMD_ALUCMP) begin
			if (opUIxt == exOpPkg::UIXT_CMPGT)
				tBit = !zero && !lessS;	// Rs > Rt signed
			else
				tBit = zero;			// CMPEQ
		end
	end

	// Packed as {lt, ovf, carry, zero, S, T}
	assign aluFlags = {lessS, ovf, carryOut, zero, sign, tBit};

	// Base plus displacement, truncated to address width
	assign memAddrNext = regValRs[`EX_ADDR_W-1:0] + immExt[`EX_ADDR_W-1:0];

endmodule

// ==== hdl/exRegFile.sv ====
`timescale 1ns/1ns
`include "exCore_macros.svh"

module exRegFile (
	input  logic                  clock,
	input  logic                  arstN,
	input  exRegPkg::regId        rdIdA,
	input  exRegPkg::regId        rdIdB,
	output logic [`EX_DATA_W-1:0] rdValA,
	output logic [`EX_DATA_W-1:0] rdValB,
	input  logic                  wrEn,
	input  exRegPkg::regId        wrId,
	input  logic [`EX_DATA_W-1:0] wrVal,
	input  logic                  srWrEn,
	input  exRegPkg::srVal        srIn,
	output exRegPkg::srVal        srOut
);

	logic [`EX_DATA_W-1:0] gpr [1:15];	// ZZR has no storage
	exRegPkg::srVal        srReg;
	logic                  wrLive;		// Write that actually lands

	assign wrLive = wrEn && (wrId != exRegPkg::REG_ZZR);

	// Read ports, write-through so EX1 sees the EX2 result this cycle
	assign rdValA = (rdIdA == exRegPkg::REG_ZZR) ? '0 :		// Hardwired zero
		(wrLive && (wrId == rdIdA)) ? wrVal : gpr[rdIdA];	// Bypass the pending write
	assign rdValB = (rdIdB == exRegPkg::REG_ZZR) ? '0 :
		(wrLive && (wrId == rdIdB)) ? wrVal : gpr[rdIdB];

	always_ff @(posedge clock) begin
		if (wrLive)
			gpr[wrId] <= wrVal;			// Writeback from EX2
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			srReg <= '0;
		else if (srWrEn)
			srReg <= srIn;				// Merged flags from EX2
	end

	assign srOut = srReg;

endmodule

// ==== hdl/exPipeLatch.sv ====
`timescale 1ns/1ns

module exPipeLatch #(
	parameter type payloadT = logic [7:0],
	parameter payloadT resetVal = payloadT'('0)
) (
	input  logic    clock,
	input  logic    arstN,
	input  logic    hold,		// Stall, keep current contents
	input  logic    flush,		// Load bubble instead of d
	input  payloadT d,
	output payloadT q
);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			q <= resetVal;		// Pipe starts empty
		end else if (!hold) begin
			if (flush)
				q <= resetVal;	// Bubble
			else
				q <= d;			// Normal advance
		end
	end

endmodule

// ==== hdl/exRegPkg.sv ====
package exRegPkg;

	// GPR number, 16 entries
	typedef logic [3:0] regId;

	// Zero register, reads 0 and drops writes
	localparam regId REG_ZZR = 4'd0;

	// Status register value
	typedef logic [7:0] srVal;

	// Flags out of EX1
	// [0] T, [1] S, [2] zero, [3] carry, [4] overflow, [5] signed less-than
	typedef logic [5:0] aluFlag;

	// SR field positions
	typedef enum int unsigned {
		SR_T     = 0,	// Compare result / zero for ADD,SUB
		SR_S     = 1,	// Sign of result
		SR_CV_LO = 4,	// Low bit of carry/overflow nibble
		SR_CV_HI = 7	// High bit of the nibble
	} srBit;

endpackage

// ==== hdl/exOpPkg.sv ====
package exOpPkg;

	// Micro-op command field
	typedef enum logic [5:0] {
		UCMD_NOP    = 6'h00,	// No operation
		UCMD_MOV_IR = 6'h01,	// Rn = Imm
		UCMD_ALU3   = 6'h02,	// Rn = Rs op Rt
		UCMD_ALUCMP = 6'h03,	// SR.T = Rs cmp Rt, no GPR write
		UCMD_MOV_MR = 6'h04,	// Rn = mem[Rs + Imm]
		UCMD_IXT    = 6'h05		// Extended op, sub-op in uIxt
	} uCmd;

	// Sub-op field, meaning depends on uCmd
	typedef enum logic [5:0] {
		UIXT_ADD   = 6'h00,		// ALU3
		UIXT_SUB   = 6'h01,		// ALU3
		UIXT_AND   = 6'h02,		// ALU3, SR untouched
		UIXT_OR    = 6'h03,		// ALU3, SR untouched
		UIXT_CMPEQ = 6'h08,		// ALUCMP, equal
		UIXT_CMPGT = 6'h09,		// ALUCMP, signed greater
		UIXT_NOP   = 6'h10,		// IXT
		UIXT_SLEEP = 6'h11		// IXT, timed stall
	} uIxt;

	// Command and sub-op latched together between EX1 and EX2
	typedef struct packed {
		uCmd cmd;
		uIxt ixt;
	} uOp;

	// Bubble value for the op latch
	localparam uOp UOP_NOP = '{cmd: UCMD_NOP, ixt: UIXT_NOP};

endpackage

// ==== hdl/exCore_macros.svh ====
`ifndef EX_CORE_MACROS_SVH
`define EX_CORE_MACROS_SVH

// Datapath width of GPRs, ALU and load data
`define EX_DATA_W 64

// Load address width
`define EX_ADDR_W 48

// Immediate width from decode, sign extended in EX1
`define EX_IMM_W 33

// SLEEP hold length in cycles, must fit the 4-bit hold counter
`define EX_SLEEP_CYC 15

`endif
